// File: compile.f
src/gpio_pkg.sv
src/gpio_bank_decoder.sv
src/gpio_bank.sv
src/gpio_resp_merge.sv
src/gpio_subsys_top.sv
dv/gpio_subsys_asserts.sv
dv/gpio_subsys_checker.sv
dv/gpio_subsys_tb.sv

// File: dv/gpio_subsys_asserts.sv
////////////////////
// Handshake assertions on the GPIO subsystem slave port
// Response hold, AW/W ready pairing, one write in flight
////////////////////

`default_nettype none

module gpio_subsys_asserts (
  input logic bus,
  input logic rst_n,
  input logic awvalid,
  input logic awready,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  // Write open from AW handshake to B handshake
  logic w_open;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      w_open <= 1'b0;
    end else if (awvalid && awready) begin
      w_open <= 1'b1;
    end else if (bvalid && bready) begin
      w_open <= 1'b0;
    end
  end

  bvalid_hold: assert property (@(posedge bus) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge bus) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // AW and W always taken together
  aw_w_ready_equal: assert property (@(posedge bus) disable iff (!rst_n)
    awready == wready)
    else $error("awready and wready differ");

  // Includes the B handshake cycle itself
  single_write: assert property (@(posedge bus) disable iff (!rst_n)
    w_open |-> !(awvalid && awready))
    else $error("second AW accepted before the B handshake");

endmodule

`default_nettype wire

// File: dv/gpio_subsys_checker.sv
////////////////////
// Response checker of the GPIO subsystem testbench
// Register model, expected B and R responses, pin comparison
////////////////////

`default_nettype none

module gpio_subsys_checker #(
  parameter int unsigned NBANKS = 4,
  parameter int unsigned DW     = 8
) (
  input  logic                        bus,
  input  logic                        rst_n,
  input  logic                        awvalid,
  input  logic                        awready,
  input  logic [gpio_pkg::ADDR_W-1:0] awaddr,
  input  logic [gpio_pkg::DATA_W-1:0] wdata,
  input  logic                        bvalid,
  input  logic                        bready,
  input  logic [1:0]                  bresp,
  input  logic                        arvalid,
  input  logic                        arready,
  input  logic [gpio_pkg::ADDR_W-1:0] araddr,
  input  logic                        rvalid,
  input  logic                        rready,
  input  logic [gpio_pkg::DATA_W-1:0] rdata,
  input  logic [1:0]                  rresp,
  input  logic [NBANKS*DW-1:0]        gpio_e,
  input  logic [NBANKS*DW-1:0]        gpio_o,
  input  logic [NBANKS*DW-1:0]        gpio_i,
  output logic [31:0]                 test_count,
  output logic [31:0]                 err_count
);

  import gpio_pkg::*;

  // Model of REG_DIR and REG_OUT, laid out like the pins
  logic [NBANKS*DW-1:0] dir_m;
  logic [NBANKS*DW-1:0] out_m;
  // Requests waiting for their response
  logic [ADDR_W-1:0]    wq_addr [$];
  logic [DATA_W-1:0]    wq_data [$];
  logic [ADDR_W-1:0]    rq_addr [$];
  logic [DATA_W-1:0]    rq_data [$];
  // Back-pressure tracking
  logic                 reset_checked;
  logic                 b_stall;
  logic                 r_stall;
  logic [1:0]           bresp_q;
  logic [1:0]           rresp_q;
  logic [DATA_W-1:0]    rdata_q;

  task automatic compare_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got, inout logic bad);
    if (exp !== got) begin
      $display("FAIL test %0d %s: expected 0x%h, got 0x%h", test_count + 1, name, exp, got);
      err_count = err_count + 1;
      bad = 1'b1;
    end
  endtask

  // Every bank slice of both pin outputs
  task automatic compare_pins(inout logic bad);
    for (int i = 0; i < NBANKS; i++) begin
      compare_value($sformatf("gpio_e[%0d]", i), DATA_W'(dir_m[i*DW +: DW]),
                    DATA_W'(gpio_e[i*DW +: DW]), bad);
      compare_value($sformatf("gpio_o[%0d]", i), DATA_W'(out_m[i*DW +: DW]),
                    DATA_W'(gpio_o[i*DW +: DW]), bad);
    end
  endtask

  task automatic finish_test(input string what, input logic bad);
    test_count = test_count + 1;
    if (bad) begin
      $display("test %0d: %s, mismatch", test_count, what);
    end else begin
      $display("test %0d: %s, ok", test_count, what);
    end
  endtask

  // Bank index from the upper bits, zero outside the bank range
  function automatic logic [DATA_W-1:0] read_value(input logic [ADDR_W-1:0] addr);
    int unsigned       b;
    logic [DATA_W-1:0] v;
    b = 32'(addr[ADDR_W-1:BANK_SHIFT]);
    v = '0;
    if (b < NBANKS) begin
      case (addr[REG_AW-1:0])
        REG_DIR: v[DW-1:0] = dir_m[b*DW +: DW];
        REG_OUT: v[DW-1:0] = out_m[b*DW +: DW];
        REG_IN:  v[DW-1:0] = gpio_i[b*DW +: DW];
        default: v = '0;
      endcase
    end
    return v;
  endfunction

  always @(posedge bus) begin : watch
    logic              bad;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    int unsigned       b;
    bad = 1'b0;
    if (!rst_n) begin
      dir_m         = '0;
      out_m         = '0;
      test_count    = '0;
      err_count     = '0;
      reset_checked = 1'b0;
      b_stall       = 1'b0;
      r_stall       = 1'b0;
      wq_addr.delete();
      wq_data.delete();
      rq_addr.delete();
      rq_data.delete();
    end else begin
      // Reset values, seen on the first cycle out of reset
      if (!reset_checked) begin
        compare_pins(bad);
        compare_value("bvalid", '0, DATA_W'(bvalid), bad);
        compare_value("rvalid", '0, DATA_W'(rvalid), bad);
        finish_test("reset state", bad);
        reset_checked = 1'b1;
        bad           = 1'b0;
      end
      // Stalled responses keep valid and payload
      if (b_stall) begin
        if (!bvalid) begin
          $display("Error in test %0d: bvalid dropped while bready was low", test_count + 1);
          err_count = err_count + 1;
        end else begin
          compare_value("bresp", DATA_W'(bresp_q), DATA_W'(bresp), bad);
        end
      end
      if (r_stall) begin
        if (!rvalid) begin
          $display("Error in test %0d: rvalid dropped while rready was low", test_count + 1);
          err_count = err_count + 1;
        end else begin
          compare_value("rdata", rdata_q, rdata, bad);
          compare_value("rresp", DATA_W'(rresp_q), DATA_W'(rresp), bad);
        end
      end
      // Requests
      if (awvalid && awready) begin
        wq_addr.push_back(awaddr);
        wq_data.push_back(wdata);
      end
      if (arvalid && arready) begin
        rq_addr.push_back(araddr);
        rq_data.push_back(read_value(araddr));
      end
      // Write response, model updated here
      if (bvalid && bready) begin
        if (wq_addr.size() == 0) begin
          $display("Error: B response arrived with no write outstanding");
          err_count = err_count + 1;
        end else begin
          a = wq_addr.pop_front();
          d = wq_data.pop_front();
          b = 32'(a[ADDR_W-1:BANK_SHIFT]);
          if (b < NBANKS) begin
            if (a[REG_AW-1:0] == REG_DIR) begin
              dir_m[b*DW +: DW] = d[DW-1:0];
            end else if (a[REG_AW-1:0] == REG_OUT) begin
              out_m[b*DW +: DW] = d[DW-1:0];
            end
            compare_value("bresp", DATA_W'(RESP_OKAY), DATA_W'(bresp), bad);
          end else begin
            compare_value("bresp", DATA_W'(RESP_SLVERR), DATA_W'(bresp), bad);
          end
          // Bank write lands one cycle before B
          compare_pins(bad);
          finish_test($sformatf("write 0x%h <- 0x%h", a, d), bad);
        end
      end
      // Read response
      if (rvalid && rready) begin
        if (rq_addr.size() == 0) begin
          $display("Error: R response arrived with no read outstanding");
          err_count = err_count + 1;
        end else begin
          a = rq_addr.pop_front();
          d = rq_data.pop_front();
          b = 32'(a[ADDR_W-1:BANK_SHIFT]);
          compare_value("rdata", d, rdata, bad);
          if (b < NBANKS) begin
            compare_value("rresp", DATA_W'(RESP_OKAY), DATA_W'(rresp), bad);
          end else begin
            compare_value("rresp", DATA_W'(RESP_SLVERR), DATA_W'(rresp), bad);
          end
          finish_test($sformatf("read 0x%h -> 0x%h", a, rdata), bad);
        end
      end
      b_stall = bvalid && !bready;
      r_stall = rvalid && !rready;
      bresp_q = bresp;
      rresp_q = rresp;
      rdata_q = rdata;
    end
  end

endmodule

`default_nettype wire

// File: dv/gpio_subsys_tb.sv
////////////////////
// Testbench top of the GPIO subsystem
// Clock, reset, random bus master, pin stimulus
// Watchdog and closing summary
////////////////////

`default_nettype none

module gpio_subsys_tb;

  import gpio_pkg::*;

  localparam int unsigned NBANKS     = 4;
  localparam int unsigned DW         = 8;
  localparam int unsigned PINS       = NBANKS * DW;
  localparam int unsigned IDX_W      = ADDR_W - BANK_SHIFT;
  localparam int unsigned NUM_RANDOM = 400;
  // Upper bound with at most two transactions per random step
  localparam int unsigned NUM_TESTS  = 1 + 2 * NBANKS + 2 * NUM_RANDOM;

  logic              bus;
  logic              rst_n;
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic              bvalid;
  logic              bready;
  resp_e             bresp;
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  resp_e             rresp;
  logic [PINS-1:0]   gpio_e;
  logic [PINS-1:0]   gpio_o;
  logic [PINS-1:0]   gpio_i;
  logic [31:0]       test_count;
  logic [31:0]       err_count;
  integer            seed;
  logic [ADDR_W-1:0] addr;
  int unsigned       op;

  gpio_subsys_top #(
    .NBANKS (NBANKS),
    .DW     (DW)
  ) gpio_subsys_top_inst (
    .bus     (bus),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .gpio_e  (gpio_e),
    .gpio_o  (gpio_o),
    .gpio_i  (gpio_i)
  );

  bind gpio_subsys_top gpio_subsys_asserts gpio_subsys_asserts_inst (
    .bus     (bus),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  gpio_subsys_checker #(
    .NBANKS (NBANKS),
    .DW     (DW)
  ) gpio_subsys_checker_inst (
    .bus        (bus),
    .rst_n      (rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wdata      (wdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .gpio_e     (gpio_e),
    .gpio_o     (gpio_o),
    .gpio_i     (gpio_i),
    .test_count (test_count),
    .err_count  (err_count)
  );

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  // Mostly valid banks with some just above and some anywhere
  // Offsets of the three registers or any nibble
  function automatic logic [ADDR_W-1:0] random_addr();
    logic [IDX_W-1:0]  idx;
    logic [REG_AW-1:0] off;
    int unsigned       pick;
    pick = $unsigned($random(seed)) % 6;
    if (pick < NBANKS) begin
      idx = IDX_W'(pick);
    end else if (pick == 4) begin
      idx = IDX_W'(NBANKS + $unsigned($random(seed)) % 4);
    end else begin
      idx = IDX_W'($random(seed));
    end
    pick = $unsigned($random(seed)) % 5;
    off  = (pick < 4) ? REG_AW'(pick * 4) : REG_AW'($random(seed));
    return {idx, off};
  endfunction

  // AW and W together, held until accepted
  // Entered and left 1 unit after a rising edge
  task automatic send_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    awaddr  = a;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge bus);
    while (!awready) @(posedge bus);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // Random stretch of B back-pressure, then the B handshake
  task automatic wait_bresp();
    if (!bready) begin
      repeat ($unsigned($random(seed)) % 8) begin
        @(posedge bus);
        #1;
      end
      bready = 1'b1;
    end
    @(posedge bus);
    while (!bvalid) @(posedge bus);
    #1;
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    send_write(a, d);
    wait_bresp();
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] a);
    araddr  = a;
    arvalid = 1'b1;
    @(posedge bus);
    while (!arready) @(posedge bus);
    #1;
    arvalid = 1'b0;
    if (!rready) begin
      repeat ($unsigned($random(seed)) % 8) begin
        @(posedge bus);
        #1;
      end
      rready = 1'b1;
    end
    @(posedge bus);
    while (!rvalid) @(posedge bus);
    #1;
  endtask

  initial begin
    seed    = 32'h489e;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    gpio_i  = '0;
    addr    = '0;
    op      = 0;
    repeat (8) @(posedge bus);
    #1 rst_n = 1'b1;
    @(posedge bus);
    #1;
    // Reset values of every bank
    for (int b = 0; b < NBANKS; b++) begin
      read_reg(ADDR_W'(b << BANK_SHIFT) | ADDR_W'(REG_DIR));
      read_reg(ADDR_W'(b << BANK_SHIFT) | ADDR_W'(REG_OUT));
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      // New pins and readies that settle through the synchroniser
      gpio_i = PINS'($random(seed));
      bready = 1'($random(seed));
      rready = 1'($random(seed));
      repeat (3) @(posedge bus);
      #1;
      addr = random_addr();
      op   = $unsigned($random(seed)) % 3;
      if (op == 0) begin
        send_write(addr, $random(seed));
        // Next write already waiting while the first B is outstanding
        awaddr  = random_addr();
        wdata   = $random(seed);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_bresp();
        write_reg(awaddr, wdata);
      end else if (op == 1) begin
        read_reg(addr);
      end else begin
        write_reg(addr, $random(seed));
        read_reg(addr);
      end
    end
    repeat (4) @(posedge bus);
    $display("Summary: %0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (2000 * NUM_TESTS) @(posedge bus);
    $display("Timeout: run did not finish within %0d cycles", 2000 * NUM_TESTS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: run_verilator.sh
#!/bin/sh
# Build the GPIO subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module gpio_subsys_tb \
  -f compile.f -o gpio_sim || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/gpio_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// File: src/gpio_bank.sv
////////////////////
// One GPIO bank
// Direction and output registers, two flop input synchroniser
// Register port with valid/ready request and response channels
////////////////////

`default_nettype none

module gpio_bank #(
  parameter int unsigned DW = 8
) (
  input  logic                        bus,
  input  logic                        rst_n,
  // Write request
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [gpio_pkg::REG_AW-1:0] waddr,
  input  logic [gpio_pkg::DATA_W-1:0] wdata,
  // Read request
  input  logic                        rvalid,
  output logic                        rready,
  input  logic [gpio_pkg::REG_AW-1:0] raddr,
  // Write response, always OKAY
  output logic                        b_valid,
  input  logic                        b_ready,
  // Read response, always OKAY
  output logic                        r_valid,
  input  logic                        r_ready,
  output logic [gpio_pkg::DATA_W-1:0] r_data,
  // Pins
  output logic [DW-1:0]               gpio_e,
  output logic [DW-1:0]               gpio_o,
  input  logic [DW-1:0]               gpio_i
);

  import gpio_pkg::*;

  logic          w_trn;
  logic          r_trn;
  // Input synchroniser stages
  logic [DW-1:0] gpio_meta;
  logic [DW-1:0] gpio_sync;

  ////////////////////
  // Write access
  ////////////////////

  // No new write while a B response waits
  assign wready = ~b_valid;
  assign w_trn  = wvalid & wready;

  // Direction and output registers
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      gpio_e <= '0;
      gpio_o <= '0;
    end else if (w_trn) begin
      case (gpio_reg_e'(waddr))
        REG_DIR: gpio_e <= wdata[DW-1:0];
        REG_OUT: gpio_o <= wdata[DW-1:0];
        // REG_IN and unused offsets, answered but dropped
        default: ;
      endcase
    end
  end

  // B valid, held until accepted
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      b_valid <= 1'b0;
    end else begin
      b_valid <= w_trn | (b_valid & ~b_ready);
    end
  end

  ////////////////////
  // Input pins
  ////////////////////

  // Two flops, pin change visible 2 cycles later
  always_ff @(posedge bus) begin
    gpio_meta <= gpio_i;
    gpio_sync <= gpio_meta;
  end

  ////////////////////
  // Read access
  ////////////////////

  assign rready = ~r_valid;
  assign r_trn  = rvalid & rready;

  // Read data zero extended, unknown offsets read zero
  always_ff @(posedge bus) begin
    if (r_trn) begin
      case (gpio_reg_e'(raddr))
        REG_DIR: r_data <= DATA_W'(gpio_e);
        REG_OUT: r_data <= DATA_W'(gpio_o);
        REG_IN:  r_data <= DATA_W'(gpio_sync);
        default: r_data <= '0;
      endcase
    end
  end

  // R valid, held until accepted
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= r_trn | (r_valid & ~r_ready);
    end
  end

endmodule

`default_nettype wire

// File: src/gpio_bank_decoder.sv
////////////////////
// Bank decoder of the GPIO subsystem
// Accepts AW/W and AR, picks a bank from the upper address bits
// Raises its own error response for out of range banks
////////////////////

`default_nettype none

module gpio_bank_decoder #(
  parameter int unsigned NBANKS = 4
) (
  input  logic                          bus,
  input  logic                          rst_n,
  // Slave request channels
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [gpio_pkg::ADDR_W-1:0]   awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [gpio_pkg::DATA_W-1:0]   wdata,
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [gpio_pkg::ADDR_W-1:0]   araddr,
  // Slave response handshakes, from the merger
  input  logic                          bvalid,
  input  logic                          bready,
  input  logic                          rvalid,
  input  logic                          rready,
  // Requests toward the banks
  output logic [NBANKS-1:0]             bank_wvalid,
  input  logic [NBANKS-1:0]             bank_wready,
  output logic [gpio_pkg::REG_AW-1:0]   bank_waddr,
  output logic [gpio_pkg::DATA_W-1:0]   bank_wdata,
  output logic [NBANKS-1:0]             bank_rvalid,
  input  logic [NBANKS-1:0]             bank_rready,
  output logic [gpio_pkg::REG_AW-1:0]   bank_raddr,
  // Decode error responder
  output logic                          err_bvalid,
  input  logic                          err_bready,
  output logic                          err_rvalid,
  input  logic                          err_rready
);

  import gpio_pkg::*;

  // All upper address bits form the index, so aliasing never hides an error
  localparam int unsigned IDX_W = ADDR_W - BANK_SHIFT;

  chan_state_e      w_state;
  chan_state_e      r_state;
  logic             aw_hs;
  logic             ar_hs;
  // Registered requests
  logic             w_pend;
  logic             w_err;
  logic [IDX_W-1:0] w_idx;
  logic             r_pend;
  logic             r_err;
  logic [IDX_W-1:0] r_idx;
  // Selected bank ready
  logic             w_bank_rdy;
  logic             r_bank_rdy;

  ////////////////////
  // Write channel
  ////////////////////

  // AW and W taken together, only when idle
  assign awready = awvalid & wvalid & (w_state == CH_IDLE);
  assign wready  = awready;
  assign aw_hs   = awvalid & awready;

  // Busy from the AW/W handshake until the slave B handshake
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      w_state <= CH_IDLE;
    end else if (aw_hs) begin
      w_state <= CH_BUSY;
    end else if (bvalid & bready) begin
      w_state <= CH_IDLE;
    end
  end

  // Request payload, split into index and offset
  always_ff @(posedge bus) begin
    if (aw_hs) begin
      w_idx      <= awaddr[ADDR_W-1:BANK_SHIFT];
      w_err      <= awaddr[ADDR_W-1:BANK_SHIFT] >= IDX_W'(NBANKS);
      bank_waddr <= awaddr[REG_AW-1:0];
      bank_wdata <= wdata;
    end
  end

  // One hot valid toward the indexed bank
  always_comb begin
    bank_wvalid = '0;
    w_bank_rdy  = 1'b0;
    for (int i = 0; i < NBANKS; i++) begin
      if (w_idx == IDX_W'(i)) begin
        bank_wvalid[i] = w_pend & ~w_err;
        w_bank_rdy     = bank_wready[i];
      end
    end
  end

  // Pending until the bank takes it, or one cycle for an error
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      w_pend     <= 1'b0;
      err_bvalid <= 1'b0;
    end else begin
      w_pend     <= aw_hs | (w_pend & ~(w_err | w_bank_rdy));
      err_bvalid <= (w_pend & w_err) | (err_bvalid & ~err_bready);
    end
  end

  ////////////////////
  // Read channel
  ////////////////////

  assign arready = arvalid & (r_state == CH_IDLE);
  assign ar_hs   = arvalid & arready;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      r_state <= CH_IDLE;
    end else if (ar_hs) begin
      r_state <= CH_BUSY;
    end else if (rvalid & rready) begin
      r_state <= CH_IDLE;
    end
  end

  always_ff @(posedge bus) begin
    if (ar_hs) begin
      r_idx      <= araddr[ADDR_W-1:BANK_SHIFT];
      r_err      <= araddr[ADDR_W-1:BANK_SHIFT] >= IDX_W'(NBANKS);
      bank_raddr <= araddr[REG_AW-1:0];
    end
  end

  always_comb begin
    bank_rvalid = '0;
    r_bank_rdy  = 1'b0;
    for (int i = 0; i < NBANKS; i++) begin
      if (r_idx == IDX_W'(i)) begin
        bank_rvalid[i] = r_pend & ~r_err;
        r_bank_rdy     = bank_rready[i];
      end
    end
  end

  // Error read data is zero, supplied by the merger
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      r_pend     <= 1'b0;
      err_rvalid <= 1'b0;
    end else begin
      r_pend     <= ar_hs | (r_pend & ~(r_err | r_bank_rdy));
      err_rvalid <= (r_pend & r_err) | (err_rvalid & ~err_rready);
    end
  end

endmodule

`default_nettype wire

// File: src/gpio_pkg.sv
////////////////////
// Shared definitions of the GPIO subsystem
// Bus widths, bank address split, register offsets
// Response codes and decoder channel states
////////////////////

`default_nettype none

package gpio_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Slave address width
  localparam int unsigned ADDR_W = 16;
  // Bus data width
  localparam int unsigned DATA_W = 32;

  // log2 of the 16 byte window of one bank
  localparam int unsigned BANK_SHIFT = 4;
  // Offset bits inside one bank
  localparam int unsigned REG_AW = 4;

  ////////////////////
  // Encodings
  ////////////////////

  // Register offsets inside a bank
  typedef enum logic [3:0] {
    REG_DIR = 4'h0,  // output enable, r/w
    REG_OUT = 4'h4,  // output value, r/w
    REG_IN  = 4'h8   // synchronised pins, read only
  } gpio_reg_e;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // Per channel state of the decoder
  typedef enum logic {
    CH_IDLE = 1'b0,
    CH_BUSY = 1'b1
  } chan_state_e;

endpackage

`default_nettype wire

// File: src/gpio_resp_merge.sv
////////////////////
// Response merger of the GPIO subsystem
// Drains bank and decode error responses onto slave B and R
////////////////////

`default_nettype none

module gpio_resp_merge #(
  parameter int unsigned NBANKS = 4
) (
  // Bank responses
  input  logic [NBANKS-1:0]                       b_valid,
  output logic [NBANKS-1:0]                       b_ready,
  input  logic [NBANKS-1:0]                       r_valid,
  output logic [NBANKS-1:0]                       r_ready,
  input  logic [NBANKS-1:0][gpio_pkg::DATA_W-1:0] r_data,
  // Decode error responder
  input  logic                                    err_bvalid,
  output logic                                    err_bready,
  input  logic                                    err_rvalid,
  output logic                                    err_rready,
  // Slave B channel
  output logic                                    bvalid,
  input  logic                                    bready,
  output gpio_pkg::resp_e                         bresp,
  // Slave R channel
  output logic                                    rvalid,
  input  logic                                    rready,
  output logic [gpio_pkg::DATA_W-1:0]             rdata,
  output gpio_pkg::resp_e                         rresp
);

  import gpio_pkg::*;

  ////////////////////
  // B channel
  ////////////////////

  // One source valid at most, a plain OR is enough
  assign bvalid = (|b_valid) | err_bvalid;

  // Error responder is the only SLVERR source
  assign bresp = err_bvalid ? RESP_SLVERR : RESP_OKAY;

  // Ready back to the valid source only
  assign b_ready    = b_valid & {NBANKS{bready}};
  assign err_bready = err_bvalid & bready;

  ////////////////////
  // R channel
  ////////////////////

  assign rvalid = (|r_valid) | err_rvalid;
  assign rresp  = err_rvalid ? RESP_SLVERR : RESP_OKAY;

  // AND-OR select of bank data
  // Error reads leave it at zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < NBANKS; i++) begin
      if (r_valid[i]) begin
        rdata = rdata | r_data[i];
      end
    end
  end

  assign r_ready    = r_valid & {NBANKS{rready}};
  assign err_rready = err_rvalid & rready;

endmodule

`default_nettype wire

// File: src/gpio_subsys_top.sv
////////////////////
// Top of the multi bank GPIO subsystem
// Bank decoder, NBANKS GPIO banks, response merger
////////////////////

`default_nettype none

module gpio_subsys_top #(
  parameter int unsigned NBANKS = 4,
  parameter int unsigned DW     = 8
) (
  input  logic                        bus,
  input  logic                        rst_n,
  // AXI4-Lite slave
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [gpio_pkg::ADDR_W-1:0] awaddr,
  input  logic                        wvalid,
  output logic                        wready,
  input  logic [gpio_pkg::DATA_W-1:0] wdata,
  output logic                        bvalid,
  input  logic                        bready,
  output gpio_pkg::resp_e             bresp,
  input  logic                        arvalid,
  output logic                        arready,
  input  logic [gpio_pkg::ADDR_W-1:0] araddr,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [gpio_pkg::DATA_W-1:0] rdata,
  output gpio_pkg::resp_e             rresp,
  // Pins, bank b in slice [b*DW +: DW]
  output logic [NBANKS*DW-1:0]        gpio_e,
  output logic [NBANKS*DW-1:0]        gpio_o,
  input  logic [NBANKS*DW-1:0]        gpio_i
);

  import gpio_pkg::*;

  // Decoder to banks
  logic [NBANKS-1:0]             bank_wvalid;
  logic [NBANKS-1:0]             bank_wready;
  logic [REG_AW-1:0]             bank_waddr;
  logic [DATA_W-1:0]             bank_wdata;
  logic [NBANKS-1:0]             bank_rvalid;
  logic [NBANKS-1:0]             bank_rready;
  logic [REG_AW-1:0]             bank_raddr;
  // Banks to merger
  logic [NBANKS-1:0]             b_valid;
  logic [NBANKS-1:0]             b_ready;
  logic [NBANKS-1:0]             r_valid;
  logic [NBANKS-1:0]             r_ready;
  logic [NBANKS-1:0][DATA_W-1:0] r_data;
  // Decode error responses
  logic                          err_bvalid;
  logic                          err_bready;
  logic                          err_rvalid;
  logic                          err_rready;

  gpio_bank_decoder #(
    .NBANKS (NBANKS)
  ) gpio_bank_decoder_inst (
    .bus         (bus),
    .rst_n       (rst_n),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .bvalid      (bvalid),
    .bready      (bready),
    .rvalid      (rvalid),
    .rready      (rready),
    .bank_wvalid (bank_wvalid),
    .bank_wready (bank_wready),
    .bank_waddr  (bank_waddr),
    .bank_wdata  (bank_wdata),
    .bank_rvalid (bank_rvalid),
    .bank_rready (bank_rready),
    .bank_raddr  (bank_raddr),
    .err_bvalid  (err_bvalid),
    .err_bready  (err_bready),
    .err_rvalid  (err_rvalid),
    .err_rready  (err_rready)
  );

  ////////////////////
  // GPIO banks
  ////////////////////

  for (genvar g = 0; g < NBANKS; g++) begin : g_bank
    gpio_bank #(
      .DW (DW)
    ) gpio_bank_inst (
      .bus     (bus),
      .rst_n   (rst_n),
      .wvalid  (bank_wvalid[g]),
      .wready  (bank_wready[g]),
      .waddr   (bank_waddr),
      .wdata   (bank_wdata),
      .rvalid  (bank_rvalid[g]),
      .rready  (bank_rready[g]),
      .raddr   (bank_raddr),
      .b_valid (b_valid[g]),
      .b_ready (b_ready[g]),
      .r_valid (r_valid[g]),
      .r_ready (r_ready[g]),
      .r_data  (r_data[g]),
      .gpio_e  (gpio_e[g*DW +: DW]),
      .gpio_o  (gpio_o[g*DW +: DW]),
      .gpio_i  (gpio_i[g*DW +: DW])
    );
  end

  gpio_resp_merge #(
    .NBANKS (NBANKS)
  ) gpio_resp_merge_inst (
    .b_valid    (b_valid),
    .b_ready    (b_ready),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .r_data     (r_data),
    .err_bvalid (err_bvalid),
    .err_bready (err_bready),
    .err_rvalid (err_rvalid),
    .err_rready (err_rready),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp)
  );

endmodule

`default_nettype wire
